/* Bender.yml */
package:
  name: sdram_auto_refresh

sources:
  - files:
      - design/sdram_rfs_pkg.sv
      - design/bank_state_if.sv
      - design/sdram_bank_tracker.sv
      - design/sdram_refresh_timer.sv
      - design/sdram_refresh_sequencer.sv
      - design/sdram_auto_refresh.sv
  - target: test
    files:
      - tests/rfs_checker.sv
      - tests/tb_sdram_auto_refresh.sv

/* compile.f */
design/sdram_rfs_pkg.sv
design/bank_state_if.sv
design/sdram_bank_tracker.sv
design/sdram_refresh_timer.sv
design/sdram_refresh_sequencer.sv
design/sdram_auto_refresh.sv
tests/rfs_checker.sv
tests/tb_sdram_auto_refresh.sv

/* design/bank_state_if.sv */
`timescale 1ns/10ps

// bank bookkeeping shared by tracker, timer and sequencer
interface bank_state_if;
    import sdram_rfs_pkg::*;

    bank_mask_t                   bank_idle;     // 1 = bank precharged
    logic                         next_all_idle; // all idle after this cycle's command
    row_addr_t [num_banks-1:0]    active_row;    // row held by each open bank

    modport tracker (
        output bank_idle,
        output next_all_idle,
        output active_row
    );

    modport timer (
        input next_all_idle
    );

    modport sequencer (
        input bank_idle,
        input next_all_idle,
        input active_row
    );

endinterface

/* design/sdram_auto_refresh.sv */
`timescale 1ns/10ps

module sdram_auto_refresh #(
    parameter real    clk_period_ns         = 7.0,
    parameter real    refresh_itv_ns        = 64.0 * 1000.0 * 1000.0 / 4096.0 * 0.8,
    parameter real    forced_refresh_itv_ns = 64.0 * 1000.0 * 1000.0 / 4096.0 * 0.9,
    parameter int     burst_len             = -1,   // -1 for full page, else 1/2/4/8
    parameter bit     allow_auto_precharge  = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_rfs_timing_i,
    input  sdram_rfs_pkg::cmd_word_t mon_cmd_i,
    input  logic                     mon_valid_i,
    input  logic                     mon_ready_i,
    output sdram_rfs_pkg::cmd_word_t rfs_cmd_o,
    output logic                     rfs_valid_o,
    input  logic                     rfs_ready_i,
    output logic                     rfs_running_o
);

    localparam int refresh_itv_cycles = int'($floor(refresh_itv_ns / clk_period_ns));
    localparam int forced_itv_cycles  = int'($floor(forced_refresh_itv_ns / clk_period_ns));

    // full-page bursts never carry auto precharge
    localparam bit rw_auto_precharge = (burst_len == -1) ? 1'b0 : allow_auto_precharge;

    logic rfs_launch;

    bank_state_if bank_if ();

    sdram_bank_tracker #(
        .rw_auto_precharge (rw_auto_precharge)
    ) u_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .mon_cmd_i   (mon_cmd_i),
        .mon_valid_i (mon_valid_i),
        .mon_ready_i (mon_ready_i),
        .bank_o      (bank_if.tracker)
    );

    sdram_refresh_timer #(
        .refresh_itv_cycles (refresh_itv_cycles),
        .forced_itv_cycles  (forced_itv_cycles)
    ) u_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_rfs_timing_i),
        .bank_i       (bank_if.timer),
        .rfs_launch_o (rfs_launch)
    );

    sdram_refresh_sequencer u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .rfs_launch_i  (rfs_launch),
        .bank_i        (bank_if.sequencer),
        .rfs_ready_i   (rfs_ready_i),
        .rfs_cmd_o     (rfs_cmd_o),
        .rfs_valid_o   (rfs_valid_o),
        .rfs_running_o (rfs_running_o)
    );

endmodule

/* design/sdram_bank_tracker.sv */
`timescale 1ns/10ps

module sdram_bank_tracker #(
    parameter bit rw_auto_precharge = 1'b1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  sdram_rfs_pkg::cmd_word_t mon_cmd_i,
    input  logic                    mon_valid_i,
    input  logic                    mon_ready_i,
    bank_state_if.tracker           bank_o
);
    import sdram_rfs_pkg::*;

    logic       accepted;
    bank_id_t   cmd_bank;
    row_addr_t  cmd_row;
    cmd_code_t  cmd_code;
    logic       cmd_a10;
    bank_mask_t bank_onehot;

    logic       is_active;
    logic       is_precharge;
    logic       is_rw_ap;     // read/write that closes its bank

    bank_mask_t open_mask;    // banks going idle
    bank_mask_t close_mask;   // banks being activated
    bank_mask_t idle_next;

    bank_mask_t                idle_q;
    row_addr_t [num_banks-1:0] row_q;

    // monitor only counts a command on a real handshake
    assign accepted = mon_valid_i & mon_ready_i;

    assign cmd_bank = mon_cmd_i[cmd_bank_msb:cmd_bank_lsb];
    assign cmd_row  = mon_cmd_i[cmd_addr_msb:cmd_addr_lsb];
    assign cmd_code = mon_cmd_i[2:0];
    assign cmd_a10  = mon_cmd_i[cmd_a10_bit];

    assign bank_onehot = bank_mask_t'(1) << cmd_bank;

    assign is_active    = accepted & (cmd_code == cmd_bank_active);
    assign is_precharge = accepted & (cmd_code == cmd_bank_precharge);
    assign is_rw_ap     = accepted & rw_auto_precharge & cmd_a10 &
                          ((cmd_code == cmd_write_data) | (cmd_code == cmd_read_data));

    always_comb
    begin
        open_mask  = '0;
        close_mask = '0;
        if (is_precharge && cmd_a10)
            open_mask = '1; // precharge all
        else if (is_precharge || is_rw_ap)
            open_mask = bank_onehot;
        if (is_active)
            close_mask = bank_onehot;
    end

    assign idle_next = (idle_q | open_mask) & ~close_mask;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            idle_q <= '1;
        else
            idle_q <= idle_next;
    end

    // open row of each bank, only meaningful while the bank is active
    always_ff @(posedge clk)
    begin
        if (is_active)
            row_q[cmd_bank] <= cmd_row;
    end

    assign bank_o.bank_idle     = idle_q;
    assign bank_o.next_all_idle = &idle_next;
    assign bank_o.active_row    = row_q;

endmodule

/* design/sdram_refresh_sequencer.sv */
`timescale 1ns/10ps

module sdram_refresh_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rfs_launch_i,
    bank_state_if.sequencer          bank_i,
    input  logic                     rfs_ready_i,
    output sdram_rfs_pkg::cmd_word_t rfs_cmd_o,
    output logic                     rfs_valid_o,
    output logic                     rfs_running_o
);
    import sdram_rfs_pkg::*;

    localparam row_addr_t a10_only = row_addr_t'(1) << 10;

    localparam cmd_word_t pre_all_word = {bank_id_t'(0), a10_only, cmd_bank_precharge};
    localparam cmd_word_t refresh_word = {bank_id_t'(0), row_addr_t'(0), cmd_auto_refresh};

    rfs_state_t state_q;

    logic                      launch_d;
    logic                      all_idle_snap;  // no precharge/activate needed
    bank_mask_t                active_snap;    // banks to reopen
    row_addr_t [num_banks-1:0] row_snap;

    logic [2:0] walk_cnt;   // bank being reopened, 4 = done
    logic [2:0] walk_nxt;   // walk_cnt + 1, kept as a register
    logic       walk_step;

    cmd_word_t  cmd_q;
    logic       valid_q;
    logic       running_q;

    assign rfs_cmd_o     = cmd_q;
    assign rfs_valid_o   = valid_q;
    assign rfs_running_o = running_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            launch_d <= 1'b0;
        else
            launch_d <= rfs_launch_i;
    end

    always_ff @(posedge clk)
    begin
        if (rfs_launch_i)
            all_idle_snap <= bank_i.next_all_idle;
    end

    // bank state has settled one cycle after launch
    always_ff @(posedge clk)
    begin
        if (launch_d)
        begin
            active_snap <= ~bank_i.bank_idle;
            row_snap    <= bank_i.active_row;
        end
    end

    // closed banks are skipped without waiting for ready
    assign walk_step = (state_q == rfs_activate) &
                       (~active_snap[walk_cnt[1:0]] | rfs_ready_i | walk_cnt[2]);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= rfs_idle;
        else
        begin
            case (state_q)
                rfs_idle:
                    if (rfs_launch_i)
                        state_q <= bank_i.next_all_idle ? rfs_refresh : rfs_precharge_all;
                rfs_precharge_all:
                    if (rfs_ready_i)
                        state_q <= rfs_refresh;
                rfs_refresh:
                    if (rfs_ready_i)
                        state_q <= all_idle_snap ? rfs_idle : rfs_activate;
                rfs_activate:
                    if (walk_cnt[2])
                        state_q <= rfs_idle;
                default:
                    state_q <= rfs_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            walk_cnt <= 3'd0;
            walk_nxt <= 3'd1;
        end
        else if (walk_step)
        begin
            walk_cnt <= walk_cnt[2] ? 3'd0 : walk_nxt;
            walk_nxt <= walk_cnt[2] ? 3'd1 : walk_nxt + 3'd1;
        end
    end

    // command word, loaded one cycle ahead of its valid
    always_ff @(posedge clk)
    begin
        case (state_q)
            rfs_idle:
                cmd_q <= bank_i.next_all_idle ? refresh_word : pre_all_word;
            rfs_precharge_all:
                if (rfs_ready_i)
                    cmd_q <= refresh_word;
            rfs_refresh:
                if (rfs_ready_i && !all_idle_snap)
                    cmd_q <= {bank_id_t'(0), row_snap[0], cmd_bank_active};
            rfs_activate:
                if (walk_step && !walk_cnt[2])
                    cmd_q <= {bank_id_t'(walk_nxt[1:0]), row_snap[walk_nxt[1:0]],
                              cmd_bank_active};
            default:
                cmd_q <= cmd_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_q <= 1'b0;
        else
        begin
            case (state_q)
                rfs_idle:
                    valid_q <= rfs_launch_i;
                rfs_refresh:
                    if (rfs_ready_i)
                        valid_q <= all_idle_snap ? 1'b0 : active_snap[0];
                rfs_activate:
                    if (walk_cnt[2])
                        valid_q <= 1'b0;
                    else if (walk_step)
                        valid_q <= (walk_cnt != 3'd3) & active_snap[walk_nxt[1:0]];
                default:
                    valid_q <= valid_q; // precharge waits for ready
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            running_q <= 1'b0;
        else
        begin
            case (state_q)
                rfs_idle:
                    running_q <= rfs_launch_i;
                rfs_refresh:
                    running_q <= ~(rfs_ready_i & all_idle_snap);
                rfs_activate:
                    running_q <= ~walk_cnt[2];
                default:
                    running_q <= running_q;
            endcase
        end
    end

endmodule

/* design/sdram_refresh_timer.sv */
`timescale 1ns/10ps

module sdram_refresh_timer #(
    parameter int refresh_itv_cycles = 40,
    parameter int forced_itv_cycles  = 60
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    bank_state_if.timer bank_i,
    output logic        rfs_launch_o
);

    localparam int cnt_w = (forced_itv_cycles > 2) ? $clog2(forced_itv_cycles) : 1;

    typedef logic [cnt_w-1:0] itv_cnt_t;

    localparam itv_cnt_t alarm_last  = itv_cnt_t'(refresh_itv_cycles - 1);
    localparam itv_cnt_t forced_last = itv_cnt_t'(forced_itv_cycles - 1);

    logic     cnt_en;       // set once by start_i
    itv_cnt_t itv_cnt;
    logic     alarm_q;      // refresh due, waiting for idle banks
    logic     forced_q;     // interval ran out, refresh regardless
    logic     launch_d;

    // alarm waits for a quiet cycle, forced does not
    assign rfs_launch_o = (alarm_q & bank_i.next_all_idle) | forced_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt_en <= 1'b0;
        else if (start_i)
            cnt_en <= 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            launch_d <= 1'b0;
        else
            launch_d <= rfs_launch_o;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            itv_cnt <= '0;
        else if (launch_d)
            itv_cnt <= '0; // restart interval from the refresh
        else if (cnt_en)
            itv_cnt <= (itv_cnt == forced_last) ? '0 : itv_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            alarm_q <= 1'b0;
        else if (rfs_launch_o)
            alarm_q <= 1'b0;
        else if (!alarm_q)
            alarm_q <= (itv_cnt == alarm_last);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            forced_q <= 1'b0;
        else
            forced_q <= (itv_cnt == forced_last); // single-cycle pulse
    end

endmodule

/* design/sdram_rfs_pkg.sv */
package sdram_rfs_pkg;

    localparam int num_banks = 4;

    typedef logic [1:0]  bank_id_t;   // BA1..BA0
    typedef logic [10:0] row_addr_t;  // A10..A0
    typedef logic [3:0]  bank_mask_t; // one bit per bank
    typedef logic [2:0]  cmd_code_t;

    // {bank[15:14], addr[13:3], code[2:0]}, A10 lands on bit 13
    typedef logic [15:0] cmd_word_t;

    localparam int cmd_bank_msb = 15;
    localparam int cmd_bank_lsb = 14;
    localparam int cmd_addr_msb = 13;
    localparam int cmd_addr_lsb = 3;
    localparam int cmd_a10_bit  = 13;

    // logical command codes, fixed by the controller's command word
    localparam cmd_code_t cmd_bank_active    = 3'b000;
    localparam cmd_code_t cmd_bank_precharge = 3'b001;
    localparam cmd_code_t cmd_write_data     = 3'b010;
    localparam cmd_code_t cmd_read_data      = 3'b011;
    localparam cmd_code_t cmd_auto_refresh   = 3'b101;

    // refresh sequencer states
    typedef enum logic [1:0] {
        rfs_idle,
        rfs_precharge_all,
        rfs_refresh,
        rfs_activate
    } rfs_state_t;

endpackage

/* tests/rfs_checker.sv */
`timescale 1ns/10ps

// watches the DUT ports, keeps a bank model and scores every refresh command
module rfs_checker #(
    parameter int forced_itv_cycles = 60,
    parameter bit rw_auto_precharge = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_rfs_timing_i,
    input  sdram_rfs_pkg::cmd_word_t mon_cmd_i,
    input  logic                     mon_valid_i,
    input  logic                     mon_ready_i,
    input  sdram_rfs_pkg::cmd_word_t rfs_cmd_i,
    input  logic                     rfs_valid_i,
    input  logic                     rfs_ready_i,
    input  logic                     rfs_running_i,
    output int                       error_count_o,
    output int                       check_count_o,
    output int                       seq_count_o
);
    import sdram_rfs_pkg::*;

    bank_mask_t                model_idle;
    row_addr_t [num_banks-1:0] model_row;
    cmd_word_t                 exp_q[$];
    cmd_word_t                 exp_word;
    cmd_word_t                 cmd_d;
    logic                      started;
    logic                      hold_open;   // banks open since the last launch
    logic                      late_seen;
    logic                      running_d;
    logic                      valid_d;
    logic                      ready_d;
    int                        cyc;
    int                        last_launch;
    int                        n;
    int                        i;

    function automatic int expected_len(input bank_mask_t idle);
        int b;
        int len;
        len = (idle == '1) ? 1 : 2;
        for (b = 0; b < num_banks; b = b + 1)
            if (!idle[b])
                len = len + 1;
        return len;
    endfunction

    // reference sequence: precharge-all if needed, refresh, reopen in bank order
    function automatic cmd_word_t expected_cmd(input bank_mask_t idle,
                                               input row_addr_t [num_banks-1:0] rows,
                                               input int idx);
        int        b;
        int        pos;
        cmd_word_t word;
        word = '0;
        pos  = 0;
        if (idle != '1)
        begin
            if (idx == pos)
                word = {2'b00, 11'h400, cmd_bank_precharge};
            pos = pos + 1;
        end
        if (idx == pos)
            word = {2'b00, 11'h000, cmd_auto_refresh};
        pos = pos + 1;
        for (b = 0; b < num_banks; b = b + 1)
        begin
            if (!idle[b])
            begin
                if (idx == pos)
                    word = {bank_id_t'(b), rows[b], cmd_bank_active};
                pos = pos + 1;
            end
        end
        return word;
    endfunction

    // only the fields that carry meaning for each command
    function automatic bit cmd_matches(input cmd_word_t got, input cmd_word_t exp);
        if (got[2:0] !== exp[2:0])
            return 1'b0;
        if (exp[2:0] == cmd_bank_precharge)
            return got[13] === exp[13];
        if (exp[2:0] == cmd_bank_active)
            return got[15:3] === exp[15:3];
        return 1'b1;
    endfunction

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            model_idle    = '1;
            model_row     = '0;
            exp_q.delete();
            cmd_d         = '0;
            started       = 1'b0;
            hold_open     = 1'b0;
            late_seen     = 1'b0;
            running_d     = 1'b0;
            valid_d       = 1'b0;
            ready_d       = 1'b0;
            cyc           = 0;
            last_launch   = 0;
            error_count_o = 0;
            check_count_o = 0;
            seq_count_o   = 0;
        end
        else
        begin
            cyc = cyc + 1;
            if (!started && (rfs_valid_i || rfs_running_i))
            begin
                $display("Fail %0t: refresh activity before start_rfs_timing_i", $time);
                error_count_o++;
            end
            if (start_rfs_timing_i && !started)
            begin
                started     = 1'b1;
                last_launch = cyc;
            end
            if (valid_d && !ready_d)
            begin
                check_count_o++;
                if (!rfs_valid_i || rfs_cmd_i !== cmd_d)
                begin
                    $display("Fail %0t: held command %h changed to %h, valid %b",
                             $time, cmd_d, rfs_cmd_i, rfs_valid_i);
                    error_count_o++;
                end
            end
            if (rfs_valid_i && !rfs_running_i)
            begin
                $display("Fail %0t: rfs_valid_o high while rfs_running_o is low", $time);
                error_count_o++;
            end
            if (rfs_running_i && !running_d)
            begin
                // launch was one cycle back, model matches the DUT snapshot here
                n = expected_len(model_idle);
                for (i = 0; i < n; i = i + 1)
                    exp_q.push_back(expected_cmd(model_idle, model_row, i));
                if (hold_open)
                    check_count_o++; // forced interval held
                hold_open   = (model_idle != '1);
                last_launch = cyc - 1;
                late_seen   = 1'b0;
                seq_count_o++;
            end
            if (rfs_valid_i && rfs_ready_i)
            begin
                check_count_o++;
                if (exp_q.size() == 0)
                begin
                    $display("Fail %0t: unexpected refresh command %h", $time, rfs_cmd_i);
                    error_count_o++;
                end
                else
                begin
                    exp_word = exp_q.pop_front();
                    if (!cmd_matches(rfs_cmd_i, exp_word))
                    begin
                        $display("Fail %0t: refresh command %h, expected %h",
                                 $time, rfs_cmd_i, exp_word);
                        error_count_o++;
                    end
                end
            end
            if (!rfs_running_i && running_d && exp_q.size() != 0)
            begin
                $display("refresh sequence ended with %0d expected commands never sent",
                         exp_q.size());
                error_count_o++;
                exp_q.delete();
            end
            if (hold_open && !late_seen && !rfs_running_i &&
                cyc >= last_launch + forced_itv_cycles + 3)
            begin
                $display("no refresh started within %0d cycles of the previous launch",
                         forced_itv_cycles + 2);
                late_seen = 1'b1;
                error_count_o++;
            end
            if (mon_valid_i && mon_ready_i)
            begin
                case (mon_cmd_i[2:0])
                    cmd_bank_active:
                    begin
                        model_idle[mon_cmd_i[15:14]] = 1'b0;
                        model_row[mon_cmd_i[15:14]]  = mon_cmd_i[13:3];
                    end
                    cmd_bank_precharge:
                        if (mon_cmd_i[13])
                            model_idle = '1;
                        else
                            model_idle[mon_cmd_i[15:14]] = 1'b1;
                    cmd_write_data, cmd_read_data:
                        if (rw_auto_precharge && mon_cmd_i[13])
                            model_idle[mon_cmd_i[15:14]] = 1'b1;
                    default:
                        ;
                endcase
            end
            if (model_idle == '1)
                hold_open = 1'b0; // alarm may launch again
            running_d = rfs_running_i;
            valid_d   = rfs_valid_i;
            ready_d   = rfs_ready_i;
            cmd_d     = rfs_cmd_i;
        end
    end

endmodule

/* tests/tb_sdram_auto_refresh.sv */
`timescale 1ns/10ps

module tb_sdram_auto_refresh;
    import sdram_rfs_pkg::*;

    localparam real clk_period_ns  = 10.0;
    localparam int  refresh_cycles = 40;
    localparam int  forced_cycles  = 60;
    localparam int  burst_len      = 8;
    localparam bit  allow_ap       = 1'b1;
    localparam bit  auto_precharge = (burst_len != -1) && allow_ap;
    localparam int  num_refreshes  = 10;
    localparam int  num_phases     = num_refreshes + 1;  // plus the pre-start window
    localparam int  cycle_limit    = num_phases * forced_cycles + 300;

    logic      clk;
    logic      rst_n;
    logic      start_rfs_timing_i;
    cmd_word_t mon_cmd_i;
    logic      mon_valid_i;
    logic      mon_ready_i;
    cmd_word_t rfs_cmd_o;
    logic      rfs_valid_o;
    logic      rfs_ready_i;
    logic      rfs_running_o;

    int        error_count;
    int        check_count;
    int        seq_count;
    int        tb_errors;
    int        cycle_cnt = 0;
    int        seed;
    logic      ready_gaps;
    logic      random_traffic;
    cmd_word_t pending[$];   // agent commands, one per cycle

    sdram_auto_refresh #(
        .clk_period_ns         (clk_period_ns),
        .refresh_itv_ns        (refresh_cycles * clk_period_ns),
        .forced_refresh_itv_ns (forced_cycles * clk_period_ns),
        .burst_len             (burst_len),
        .allow_auto_precharge  (allow_ap)
    ) dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .start_rfs_timing_i (start_rfs_timing_i),
        .mon_cmd_i          (mon_cmd_i),
        .mon_valid_i        (mon_valid_i),
        .mon_ready_i        (mon_ready_i),
        .rfs_cmd_o          (rfs_cmd_o),
        .rfs_valid_o        (rfs_valid_o),
        .rfs_ready_i        (rfs_ready_i),
        .rfs_running_o      (rfs_running_o)
    );

    rfs_checker #(
        .forced_itv_cycles (forced_cycles),
        .rw_auto_precharge (auto_precharge)
    ) u_checker (
        .clk                (clk),
        .rst_n              (rst_n),
        .start_rfs_timing_i (start_rfs_timing_i),
        .mon_cmd_i          (mon_cmd_i),
        .mon_valid_i        (mon_valid_i),
        .mon_ready_i        (mon_ready_i),
        .rfs_cmd_i          (rfs_cmd_o),
        .rfs_valid_i        (rfs_valid_o),
        .rfs_ready_i        (rfs_ready_i),
        .rfs_running_i      (rfs_running_o),
        .error_count_o      (error_count),
        .check_count_o      (check_count),
        .seq_count_o        (seq_count)
    );

    always #(clk_period_ns / 2.0) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("timeout after %0d cycles, refresh sequences did not complete", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic cmd_word_t make_cmd(input bank_id_t bank, input row_addr_t addr,
                                           input cmd_code_t code);
        return {bank, addr, code};
    endfunction

    function automatic cmd_word_t random_cmd();
        cmd_code_t code;
        case ($urandom % 4)
            0: code = cmd_bank_active;
            1: code = cmd_bank_precharge;
            2: code = cmd_write_data;
            default: code = cmd_read_data;
        endcase
        return make_cmd(bank_id_t'($urandom % 4), row_addr_t'($urandom % 2048), code);
    endfunction

    // one falling edge: ready, then queued or random agent traffic
    task automatic drive_cycle();
        @(negedge clk);
        rfs_ready_i = ready_gaps ? (($urandom % 3) != 0) : 1'b1;
        if (pending.size() != 0)
        begin
            mon_cmd_i   = pending.pop_front();
            mon_valid_i = 1'b1;
            mon_ready_i = 1'b1;
        end
        else if (random_traffic)
        begin
            mon_cmd_i   = random_cmd();
            mon_valid_i = ($urandom % 2) != 0;
            mon_ready_i = ($urandom % 4) != 0;
        end
        else
        begin
            mon_valid_i = 1'b0;
            mon_ready_i = 1'b1;
        end
    endtask

    task automatic run_cycles(input int count);
        repeat (count) drive_cycle();
    endtask

    task automatic wait_refreshes(input int count);
        int k;
        for (k = 0; k < count; k = k + 1)
        begin
            while (!rfs_running_o)
                drive_cycle();
            while (rfs_running_o)
                drive_cycle();
        end
    endtask

    initial
    begin
        clk                = 1'b0;
        rst_n              = 1'b0;
        start_rfs_timing_i = 1'b0;
        mon_cmd_i          = '0;
        mon_valid_i        = 1'b0;
        mon_ready_i        = 1'b1;
        rfs_ready_i        = 1'b1;
        ready_gaps         = 1'b0;
        random_traffic     = 1'b0;
        tb_errors          = 0;
        seed               = 13537;
        seed               = $urandom(seed);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // longer than a forced interval, timer not started so DUT stays quiet
        run_cycles(forced_cycles + 10);
        start_rfs_timing_i = 1'b1;
        drive_cycle();
        start_rfs_timing_i = 1'b0;

        wait_refreshes(2); // all idle, plain refresh

        pending.push_back(make_cmd(2'd1, row_addr_t'($urandom % 2048), cmd_bank_active));
        pending.push_back(make_cmd(2'd3, row_addr_t'($urandom % 2048), cmd_bank_active));
        wait_refreshes(2); // forced refresh with reopen

        ready_gaps = 1'b1;
        pending.push_back(make_cmd(2'd0, row_addr_t'($urandom % 2048), cmd_bank_active));
        pending.push_back(make_cmd(2'd2, row_addr_t'($urandom % 2048), cmd_bank_active));
        pending.push_back(make_cmd(2'd1, row_addr_t'($urandom % 1024), cmd_bank_precharge));
        pending.push_back(make_cmd(2'd2, row_addr_t'($urandom % 2048) | 11'h400,
                                   cmd_read_data));
        wait_refreshes(2);

        random_traffic = 1'b1;
        wait_refreshes(4);
        random_traffic = 1'b0;
        ready_gaps     = 1'b0;
        run_cycles(5);

        if (seq_count != num_refreshes)
        begin
            $display("expected %0d refresh sequences but the checker saw %0d",
                     num_refreshes, seq_count);
            tb_errors++;
        end
        $display("checks %0d, errors %0d, refresh sequences %0d",
                 check_count, error_count + tb_errors, seq_count);
        if (error_count == 0 && tb_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
